//--- Makefile
# Verilator build and run for the coherent bus testbench

VERILATOR ?= verilator
TOP       ?= coherent_bus_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/100ps -Wno-fatal
FAIL_MSG  ?= TEST FAIL
PASS_MSG  ?= TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/bus_arbiter.sv
`timescale 1ns/100ps
`include "bus_params.svh"

module bus_arbiter (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic [`N_CPUS-1:0]          dREN,
    input  logic [`N_CPUS-1:0]          dWEN,
    input  logic [`N_CPUS-1:0]          ccwrite,
    input  logic                        bus_done,
    output logic                        grant_valid,
    output coherence_pkg::req_class_t   grant_class,
    output logic [$clog2(`N_CPUS)-1:0]  grant_cpu
);
    import coherence_pkg::*;

    logic               busy;       // a transaction owns the bus
    req_class_t         req_class;
    logic [`N_CPUS-1:0] req_vec;    // requesters in the winning class

    // fixed class order: evict, read-exclusive, read, invalidate
    always_comb begin
        req_class = NONE;
        req_vec = '0;
        if (|dWEN) begin
            req_class = EVICT;
            req_vec = dWEN;
        end else if (|(dREN & ccwrite)) begin
            req_class = READX;
            req_vec = dREN & ccwrite;
        end else if (|dREN) begin
            req_class = READ;
            req_vec = dREN;
        end else if (|ccwrite) begin
            req_class = INV;         // write intent on a shared line
            req_vec = ccwrite;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
            grant_valid <= 1'b0;
            grant_class <= NONE;
            grant_cpu <= '0;
        end else begin
            grant_valid <= 1'b0;
            if (!busy && req_class != NONE) begin
                busy <= 1'b1;
                grant_valid <= 1'b1;
                grant_class <= req_class;
                grant_cpu <= highest_cpu(req_vec);
            end else if (bus_done) begin
                busy <= 1'b0;       // class and cpu stay until the next grant
            end
        end
    end

endmodule

//--- design/bus_ctrl.sv
`timescale 1ns/100ps
`include "bus_params.svh"

module bus_ctrl (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  coherence_pkg::req_class_t                   grant_class,
    input  logic [$clog2(`N_CPUS)-1:0]                  grant_cpu,
    input  logic [`N_CPUS-1:0][`WORD_W-1:0]             daddr,
    input  logic [`N_CPUS-1:0][`BLOCK_WORDS*`WORD_W-1:0] dstore,
    input  logic                                        snoop_done,
    input  logic                                        any_hit,
    input  logic [$clog2(`N_CPUS)-1:0]                  supplier_cpu,
    input  logic                                        supplier_dirty,
    input  logic                                        exclusive,
    input  logic                                        l2_ready,
    input  logic [`WORD_W-1:0]                          l2_load,
    output logic [`N_CPUS-1:0]                          dwait,
    output logic [`N_CPUS-1:0][`BLOCK_WORDS*`WORD_W-1:0] dload,
    output logic [`N_CPUS-1:0]                          ccwait,
    output logic [`N_CPUS-1:0]                          ccexclusive,
    output logic                                        l2_ren,
    output logic                                        l2_wen,
    output logic [`WORD_W-1:0]                          l2_addr,
    output logic [`WORD_W-1:0]                          l2_store,
    output logic                                        bus_done
);
    import coherence_pkg::*;

    localparam int CNT_W = (`BLOCK_WORDS > 1) ? $clog2(`BLOCK_WORDS) : 1;

    bus_state_t                         state;
    bus_state_t                         next_state;
    logic [CNT_W-1:0]                   word_cnt;   // word of the block on the L2 side
    logic [`BLOCK_WORDS*`WORD_W-1:0]    blk;        // block on its way through the bus
    logic                               last_word;
    logic [`N_CPUS-1:0]                 others;
    logic                               is_read;

    assign is_read = (grant_class == READ) || (grant_class == READX);
    assign others = ~(`N_CPUS'(1) << grant_cpu);
    assign last_word = l2_ready && (word_cnt == CNT_W'(`BLOCK_WORDS - 1));

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (snoop_done) begin
                    if (grant_class == EVICT)
                        next_state = WRITEBACK;
                    else if (grant_class == INV)
                        next_state = RELEASE;   // no data to move
                    else if (any_hit)
                        next_state = TRANSFER;
                    else
                        next_state = READ_L2;
                end
            end
            TRANSFER: begin
                // a read-exclusive takes ownership so L2 may stay stale
                if (grant_class == READ && supplier_dirty)
                    next_state = WRITEBACK_MS;
                else
                    next_state = RELEASE;
            end
            READ_L2, WRITEBACK_MS, WRITEBACK: begin
                if (last_word)
                    next_state = RELEASE;
            end
            RELEASE: next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            word_cnt <= '0;
        end else begin
            state <= next_state;
            if (state != next_state)
                word_cnt <= '0;
            else if (l2_ready)
                word_cnt <= word_cnt + 1'b1;
        end
    end

    // address and block buffer
    always_ff @(posedge CLK) begin
        if (state == IDLE && snoop_done) begin
            l2_addr <= block_base(daddr[grant_cpu]);
            blk <= dstore[grant_cpu];           // the victim when evicting
        end else if (state == TRANSFER) begin
            blk <= dstore[supplier_cpu];
        end else if (l2_ready) begin
            l2_addr <= l2_addr + 1'b1;          // next word of the block
            if (state == READ_L2)
                blk[word_cnt*`WORD_W +: `WORD_W] <= l2_load;
        end
    end

    assign l2_store = blk[word_cnt*`WORD_W +: `WORD_W];

    always_comb begin
        dload = '0;
        dload[grant_cpu] = blk;
    end

    always_comb begin
        dwait = '1;
        ccwait = '0;
        ccexclusive = '0;
        l2_ren = 1'b0;
        l2_wen = 1'b0;
        bus_done = 1'b0;
        case (state)
            READ_L2: begin
                ccwait = others;
                l2_ren = !l2_ready;         // strobe drops in the ready cycle
            end
            TRANSFER: ccwait = others;
            WRITEBACK_MS, WRITEBACK: begin
                ccwait = others;
                l2_wen = !l2_ready;
            end
            RELEASE: begin
                dwait[grant_cpu] = 1'b0;
                ccexclusive[grant_cpu] = is_read && exclusive;
                bus_done = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- design/coherence_pkg.sv
`include "bus_params.svh"

package coherence_pkg;

    // bus transaction kinds, highest priority first
    typedef enum logic [2:0] {
        NONE,
        EVICT,      // victim writeback
        READX,      // write miss
        READ,       // read miss
        INV         // shared to modified upgrade
    } req_class_t;

    typedef enum logic [3:0] {
        IDLE,
        READ_L2,        // block fill from L2
        TRANSFER,       // cache to cache
        WRITEBACK_MS,   // dirty supplier copy goes to L2 as well
        WRITEBACK,      // evicted block to L2
        RELEASE         // requester sees dwait low
    } bus_state_t;

    // highest-numbered set bit of a per-CPU vector
    function automatic logic [$clog2(`N_CPUS)-1:0] highest_cpu(input logic [`N_CPUS-1:0] v);
        logic [$clog2(`N_CPUS)-1:0] id;
        id = '0;
        for (int i = 0; i < `N_CPUS; i++) begin
            if (v[i])
                id = i[$clog2(`N_CPUS)-1:0];
        end
        return id;
    endfunction

    // word address of the first word in the block
    function automatic logic [`WORD_W-1:0] block_base(input logic [`WORD_W-1:0] addr);
        return (addr >> $clog2(`BLOCK_WORDS)) << $clog2(`BLOCK_WORDS);
    endfunction

endpackage

//--- design/coherent_bus_top.sv
`timescale 1ns/100ps
`include "bus_params.svh"

module coherent_bus_top (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  logic [`N_CPUS-1:0]                          dREN,
    input  logic [`N_CPUS-1:0]                          dWEN,
    input  logic [`N_CPUS-1:0]                          ccwrite,
    input  logic [`N_CPUS-1:0][`WORD_W-1:0]             daddr,
    input  logic [`N_CPUS-1:0][`BLOCK_WORDS*`WORD_W-1:0] dstore,
    input  logic [`N_CPUS-1:0]                          ccsnoopdone,
    input  logic [`N_CPUS-1:0]                          ccsnoophit,
    input  logic [`N_CPUS-1:0]                          ccpresent,
    input  logic [`N_CPUS-1:0]                          ccdirty,
    output logic [`N_CPUS-1:0]                          dwait,
    output logic [`N_CPUS-1:0][`BLOCK_WORDS*`WORD_W-1:0] dload,
    output logic [`N_CPUS-1:0][`WORD_W-1:0]             ccsnoopaddr,
    output logic [`N_CPUS-1:0]                          ccinv,
    output logic [`N_CPUS-1:0]                          ccwait,
    output logic [`N_CPUS-1:0]                          ccexclusive
);
    import coherence_pkg::*;

    // arbiter to snoop and data stages
    logic                           grant_valid;
    req_class_t                     grant_class;
    logic [$clog2(`N_CPUS)-1:0]     grant_cpu;
    logic                           bus_done;

    // snoop result
    logic                           snoop_done;
    logic                           any_hit;
    logic [$clog2(`N_CPUS)-1:0]     supplier_cpu;
    logic                           supplier_dirty;
    logic                           exclusive;

    // L2 side
    logic                           l2_ren;
    logic                           l2_wen;
    logic                           l2_ready;
    logic [`WORD_W-1:0]             l2_addr;
    logic [`WORD_W-1:0]             l2_store;
    logic [`WORD_W-1:0]             l2_load;

    bus_arbiter bus_arbiter_inst (.*);
    snoop_unit snoop_unit_inst (.*);
    bus_ctrl bus_ctrl_inst (.*);
    l2_mem l2_mem_inst (.*);

endmodule

//--- design/l2_mem.sv
`timescale 1ns/100ps
`include "bus_params.svh"

module l2_mem (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                l2_ren,
    input  logic                l2_wen,
    input  logic [`WORD_W-1:0]  l2_addr,
    input  logic [`WORD_W-1:0]  l2_store,
    output logic                l2_ready,
    output logic [`WORD_W-1:0]  l2_load
);
    localparam int IDX_W = $clog2(`L2_DEPTH);
    localparam int LAT_W = $clog2(`L2_LATENCY + 1);

    logic [`WORD_W-1:0] mem [`L2_DEPTH];
    logic [LAT_W-1:0]   lat_cnt;        // cycles since the strobe rose
    logic               access;
    logic               done;
    logic [IDX_W-1:0]   idx;

    assign access = l2_ren || l2_wen;
    assign idx = l2_addr[IDX_W-1:0];
    assign done = access && (lat_cnt == LAT_W'(`L2_LATENCY - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lat_cnt <= '0;
            l2_ready <= 1'b0;
        end else if (!access) begin
            lat_cnt <= '0;          // strobe low restarts the count
            l2_ready <= 1'b0;
        end else begin
            lat_cnt <= lat_cnt + 1'b1;
            l2_ready <= done;
        end
    end

    // array access lands with the ready pulse
    always_ff @(posedge CLK) begin
        if (done) begin
            if (l2_wen)
                mem[idx] <= l2_store;
            else
                l2_load <= mem[idx];
        end
    end

endmodule

//--- design/snoop_unit.sv
`timescale 1ns/100ps
`include "bus_params.svh"

module snoop_unit (
    input  logic                                CLK,
    input  logic                                nRST,
    input  logic                                grant_valid,
    input  coherence_pkg::req_class_t           grant_class,
    input  logic [$clog2(`N_CPUS)-1:0]          grant_cpu,
    input  logic [`N_CPUS-1:0][`WORD_W-1:0]     daddr,
    input  logic [`N_CPUS-1:0]                  ccsnoopdone,
    input  logic [`N_CPUS-1:0]                  ccsnoophit,
    input  logic [`N_CPUS-1:0]                  ccpresent,
    input  logic [`N_CPUS-1:0]                  ccdirty,
    output logic [`N_CPUS-1:0][`WORD_W-1:0]     ccsnoopaddr,
    output logic [`N_CPUS-1:0]                  ccinv,
    output logic                                snoop_done,
    output logic                                any_hit,
    output logic [$clog2(`N_CPUS)-1:0]          supplier_cpu,
    output logic                                supplier_dirty,
    output logic                                exclusive
);
    import coherence_pkg::*;

    logic                           snooping;
    logic [`N_CPUS-1:0]             others;     // every cache but the requester
    logic [`N_CPUS-1:0]             hits;
    logic                           all_done;
    logic [$clog2(`N_CPUS)-1:0]     supplier;

    assign others = ~(`N_CPUS'(1) << grant_cpu);
    assign hits = ccsnoophit & others;
    assign all_done = &(ccsnoopdone | ~others);
    assign supplier = highest_cpu(hits);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            snooping <= 1'b0;
            snoop_done <= 1'b0;
            ccinv <= '0;
            any_hit <= 1'b0;
            supplier_cpu <= '0;
            supplier_dirty <= 1'b0;
            exclusive <= 1'b0;
        end else begin
            snoop_done <= 1'b0;
            if (grant_valid && grant_class == EVICT) begin
                snoop_done <= 1'b1;     // no snoop for a writeback
                any_hit <= 1'b0;
                exclusive <= 1'b0;
            end else if (grant_valid) begin
                snooping <= 1'b1;
                ccinv <= (grant_class == READX || grant_class == INV) ? others : '0;
            end else if (snooping && all_done) begin
                snooping <= 1'b0;
                snoop_done <= 1'b1;
                ccinv <= '0;
                any_hit <= |hits;
                supplier_cpu <= supplier;
                supplier_dirty <= (|hits) && ccdirty[supplier];
                exclusive <= ~|(ccpresent & others);    // nobody else keeps a copy
            end
        end
    end

    // snoop address for the other caches
    always_ff @(posedge CLK) begin
        if (grant_valid && grant_class != EVICT) begin
            for (int i = 0; i < `N_CPUS; i++) begin
                if (others[i])
                    ccsnoopaddr[i] <= block_base(daddr[grant_cpu]);
            end
        end
    end

endmodule

//--- dv/coherent_bus_tb.sv
`timescale 1ns/100ps
`include "bus_params.svh"

module coherent_bus_tb;
    import coherence_pkg::*;

    localparam int PERIOD = 20;
    localparam int RESET_CYCLES = 5;
    localparam int N_TXNS = 11;
    // snoop delay, stage handoffs, transfer and a full block writeback
    localparam int TXN_CYCLES = 12 + `BLOCK_WORDS * (`L2_LATENCY + 1);
    localparam int BLK_W = `BLOCK_WORDS * `WORD_W;

    typedef logic [BLK_W-1:0] blk_t;

    logic                               CLK;
    logic                               nRST;
    logic [`N_CPUS-1:0]                 dREN;
    logic [`N_CPUS-1:0]                 dWEN;
    logic [`N_CPUS-1:0]                 ccwrite;
    logic [`N_CPUS-1:0][`WORD_W-1:0]    daddr;
    logic [`N_CPUS-1:0][BLK_W-1:0]      dstore;
    logic [`N_CPUS-1:0]                 ccsnoopdone = '0;
    logic [`N_CPUS-1:0]                 ccsnoophit;
    logic [`N_CPUS-1:0]                 ccpresent;
    logic [`N_CPUS-1:0]                 ccdirty;
    logic [`N_CPUS-1:0]                 dwait;
    logic [`N_CPUS-1:0][BLK_W-1:0]      dload;
    logic [`N_CPUS-1:0][`WORD_W-1:0]    ccsnoopaddr;
    logic [`N_CPUS-1:0]                 ccinv;
    logic [`N_CPUS-1:0]                 ccwait;
    logic [`N_CPUS-1:0]                 ccexclusive;

    logic [`N_CPUS-1:0]     requests;
    logic                   l2_strobe;
    logic                   l2_ready;
    integer                 seed = 57913;
    int                     snoop_delay [`N_CPUS] = '{default: 0};
    logic [`N_CPUS-1:0]     other_req = '0;
    blk_t                   ref_l2 [logic [`WORD_W-1:0]];   // blocks written to L2 so far
    blk_t                   got_load [`N_CPUS];
    logic                   got_excl [`N_CPUS];
    time                    release_time [`N_CPUS];
    logic                   watching = 1'b0;
    logic [`N_CPUS-1:0]     inv_seen = '0;
    logic                   strobe_seen = 1'b0;
    int                     errors = 0;
    int                     test_start_errors = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;

    coherent_bus_top coherent_bus_top_inst (.*);

    assign requests = dREN | dWEN | ccwrite;
    assign l2_strobe = coherent_bus_top_inst.l2_ren || coherent_bus_top_inst.l2_wen;
    assign l2_ready = coherent_bus_top_inst.l2_ready;

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #((RESET_CYCLES + N_TXNS * TXN_CYCLES + 100) * PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

    // dwait drops for one cycle only
    for (genvar g = 0; g < `N_CPUS; g++) begin : dwait_checks
        assert property (@(posedge CLK) disable iff (!nRST) !$past(dwait[g]) |-> dwait[g])
        else begin
            $display("dwait of CPU%0d stayed low for more than one cycle", g);
            errors++;
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST) (ccinv & requests) == '0)
    else begin
        $display("ccinv was raised toward a cache with its own request pending");
        errors++;
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        l2_ready == ($past(l2_strobe, `L2_LATENCY) && !$past(l2_strobe, `L2_LATENCY + 1)))
    else begin
        $display("l2_ready did not follow the strobe rise by exactly %0d cycles", `L2_LATENCY);
        errors++;
    end

    // snoopers answer a foreign request after a few random cycles
    always @(posedge CLK) begin
        for (int i = 0; i < `N_CPUS; i++)
            other_req[i] = |(requests & ~(`N_CPUS'(1) << i));
        #2;
        for (int i = 0; i < `N_CPUS; i++) begin
            if (!other_req[i]) begin
                ccsnoopdone[i] = 1'b0;
                snoop_delay[i] = $unsigned($random(seed)) % 4;
            end else if (snoop_delay[i] > 0) begin
                snoop_delay[i]--;
            end else begin
                ccsnoopdone[i] = 1'b1;
            end
        end
    end

    always @(negedge CLK) begin
        if (watching) begin
            inv_seen = inv_seen | ccinv;
            strobe_seen = strobe_seen | l2_strobe;
        end
    end

    function automatic blk_t make_block(input int tag);
        blk_t b;
        for (int w = 0; w < `BLOCK_WORDS; w++)
            b[w*`WORD_W +: `WORD_W] = `WORD_W'((tag << 16) | w);
        return b;
    endfunction

    function automatic logic [`WORD_W-1:0] align_block(input logic [`WORD_W-1:0] addr);
        return addr & ~(`WORD_W'(`BLOCK_WORDS - 1));
    endfunction

    task automatic drive_edge();
        @(posedge CLK);
        #2;
    endtask

    task automatic set_snoop(input int cpu, input logic hit, input logic present,
                             input logic dirty, input blk_t data);
        ccsnoophit[cpu] = hit;
        ccpresent[cpu] = present;
        ccdirty[cpu] = dirty;
        dstore[cpu] = data;     // block offered when supplying
    endtask

    task automatic issue(input int cpu, input req_class_t kind,
                         input logic [`WORD_W-1:0] addr, input blk_t data);
        daddr[cpu] = addr;
        dstore[cpu] = data;
        case (kind)
            EVICT: dWEN[cpu] = 1'b1;
            READX: begin
                dREN[cpu] = 1'b1;
                ccwrite[cpu] = 1'b1;
            end
            READ: dREN[cpu] = 1'b1;
            INV: ccwrite[cpu] = 1'b1;
            default: ;
        endcase
    endtask

    // hold the request until dwait falls, then drop it on the next edge
    task automatic wait_release(input int cpu, input int limit);
        int cycles;
        cycles = 0;
        @(negedge CLK);
        while (dwait[cpu] !== 1'b0 && cycles < limit) begin
            @(negedge CLK);
            cycles++;
        end
        assert (dwait[cpu] === 1'b0)
        else begin
            $display("CPU%0d was not released within %0d cycles", cpu, limit);
            errors++;
        end
        got_load[cpu] = dload[cpu];
        got_excl[cpu] = ccexclusive[cpu];
        release_time[cpu] = $time;
        drive_edge();
        dREN[cpu] = 1'b0;
        dWEN[cpu] = 1'b0;
        ccwrite[cpu] = 1'b0;
    endtask

    task automatic check_block(input string name, input blk_t got, input blk_t exp);
        assert (got === exp)
        else begin
            $display("Error: %s = %0h, expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1)
        else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors > test_start_errors) begin
            tests_failed++;
            $display("test %0s: failed with %0d errors", name, errors - test_start_errors);
        end else begin
            $display("test %0s: passed", name);
        end
        test_start_errors = errors;
    endtask

    initial begin
        nRST = 1'b0;
        dREN = '0;
        dWEN = '0;
        ccwrite = '0;
        daddr = '0;
        dstore = '0;
        ccsnoophit = '0;
        ccpresent = '0;
        ccdirty = '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2 nRST = 1'b1;

        @(negedge CLK);
        check_block("dwait", dwait, {`N_CPUS{1'b1}});
        check_block("ccinv", ccinv, '0);
        check_block("ccwait", ccwait, '0);
        check_block("ccexclusive", ccexclusive, '0);
        end_test("reset state");

        // CPU0 evicts, CPU1 misses on the same block
        drive_edge();
        issue(0, EVICT, 'h10, make_block(1));
        ref_l2[align_block('h10)] = make_block(1);
        wait_release(0, TXN_CYCLES);
        drive_edge();
        issue(1, READ, 'h11, '0);
        wait_release(1, TXN_CYCLES);
        check_block("dload[1]", got_load[1], ref_l2[align_block('h11)]);
        check_block("ccexclusive[1]", got_excl[1], 1);
        // CPU0 snooped the aligned block of the miss
        check_block("ccsnoopaddr[0]", ccsnoopaddr[0], align_block('h11));
        end_test("evict then L2 read");

        drive_edge();
        set_snoop(0, 1'b1, 1'b1, 1'b0, make_block(2));
        issue(1, READ, 'h20, '0);
        wait_release(1, TXN_CYCLES);
        check_block("dload[1]", got_load[1], make_block(2));
        check_block("ccexclusive[1]", got_excl[1], 0);
        end_test("clean cache to cache read");

        // dirty supplier also updates L2
        drive_edge();
        set_snoop(0, 1'b1, 1'b1, 1'b1, make_block(3));
        issue(1, READ, 'h30, '0);
        ref_l2[align_block('h30)] = make_block(3);
        wait_release(1, TXN_CYCLES);
        check_block("dload[1]", got_load[1], make_block(3));
        drive_edge();
        set_snoop(0, 1'b0, 1'b0, 1'b0, '0);
        set_snoop(1, 1'b0, 1'b0, 1'b0, '0);
        issue(0, READ, 'h31, '0);
        wait_release(0, TXN_CYCLES);
        check_block("dload[0]", got_load[0], ref_l2[align_block('h31)]);
        check_block("ccexclusive[0]", got_excl[0], 1);
        end_test("dirty supplier");

        drive_edge();
        set_snoop(1, 1'b1, 1'b1, 1'b1, make_block(4));
        inv_seen = '0;
        watching = 1'b1;
        issue(0, READX, 'h40, '0);
        wait_release(0, TXN_CYCLES);
        watching = 1'b0;
        check_block("dload[0]", got_load[0], make_block(4));
        check_true(inv_seen[1], "ccinv never reached CPU1 during the read-exclusive");
        drive_edge();
        set_snoop(0, 1'b1, 1'b1, 1'b0, make_block(6));
        set_snoop(1, 1'b0, 1'b0, 1'b0, '0);
        inv_seen = '0;
        strobe_seen = 1'b0;
        watching = 1'b1;
        issue(1, INV, 'h40, '0);
        wait_release(1, TXN_CYCLES);
        watching = 1'b0;
        check_true(inv_seen[0], "ccinv never reached CPU0 during the upgrade");
        check_true(!strobe_seen, "an L2 strobe was raised during an upgrade");
        end_test("read-exclusive and invalidate");

        // eviction beats a read, then the higher CPU wins a tie
        drive_edge();
        set_snoop(0, 1'b0, 1'b0, 1'b0, '0);
        issue(0, READ, 'h10, '0);
        issue(1, EVICT, 'h50, make_block(5));
        ref_l2[align_block('h50)] = make_block(5);
        fork
            wait_release(0, 2 * TXN_CYCLES);
            wait_release(1, 2 * TXN_CYCLES);
        join
        check_true(release_time[1] < release_time[0], "the read was served before the eviction");
        check_block("dload[0]", got_load[0], ref_l2[align_block('h10)]);
        drive_edge();
        issue(0, READ, 'h50, '0);
        issue(1, READ, 'h10, '0);
        fork
            wait_release(0, 2 * TXN_CYCLES);
            wait_release(1, 2 * TXN_CYCLES);
        join
        check_true(release_time[1] < release_time[0], "CPU0 was served before CPU1");
        check_block("dload[0]", got_load[0], ref_l2[align_block('h50)]);
        check_block("dload[1]", got_load[1], ref_l2[align_block('h10)]);
        end_test("arbitration order");

        repeat (3) @(posedge CLK);
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- files.f
+incdir+include
design/coherence_pkg.sv
design/bus_arbiter.sv
design/snoop_unit.sv
design/bus_ctrl.sv
design/l2_mem.sv
design/coherent_bus_top.sv
dv/coherent_bus_tb.sv

//--- include/bus_params.svh
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// caches sharing the bus
`define N_CPUS 2

// word width and block size in words
`define WORD_W 32
`define BLOCK_WORDS 2

// shared L2, word addressed
`define L2_DEPTH 256
`define L2_LATENCY 2    // cycles from strobe rise to ready

`endif
